//--- design/cla_pkg.sv
package cla_pkg;

  parameter int WORD_WIDTH = 32;
  parameter int BLOCK_WIDTH = 8;

  typedef logic [WORD_WIDTH-1:0] word_t;

  // block summary seen by the second lookahead level
  typedef struct packed {
    logic group_generate;
    logic group_propagate;
  } group_gp_t;

  // carry into position n in lookahead form, with no ripple between positions
  // gen and prop hold the low n bits of interest, upper bits are ignored
  function automatic logic lookahead_carry(input word_t gen,
                                           input word_t prop,
                                           input logic carry_in,
                                           input int unsigned n);
    logic carry;
    logic term;
    // carry-in passed through every propagate below n
    carry = carry_in;
    for (int unsigned j = 0; j < n; j++) begin
      carry = carry & prop[j];
    end
    // generate at j, then all propagates from j+1 up to n-1
    for (int unsigned j = 0; j < n; j++) begin
      term = gen[j];
      for (int unsigned k = j + 1; k < n; k++) begin
        term = term & prop[k];
      end
      carry = carry | term;
    end
    return carry;
  endfunction

endpackage

//--- design/alu_status_pkg.sv
package alu_status_pkg;

  // operands as presented at the adder input
  // for compare, drive b inverted with carry_in high
  typedef struct packed {
    cla_pkg::word_t operand_a;
    cla_pkg::word_t operand_b;
    logic           carry_in;
  } operand_t;

  // sum plus comparison flags
  // not_equal and less_than only mean a != b and a < b in subtract mode
  typedef struct packed {
    cla_pkg::word_t sum;
    logic           overflow;
    logic           not_equal;
    logic           less_than;
  } result_t;

endpackage

//--- design/cla_block.sv
`timescale 1ns/1ps

module cla_block #(
  parameter int BLOCK_WIDTH = cla_pkg::BLOCK_WIDTH
) (
  input  logic [BLOCK_WIDTH-1:0] operand_a,
  input  logic [BLOCK_WIDTH-1:0] operand_b,
  input  logic                   carry_in,
  output logic [BLOCK_WIDTH-1:0] sum,
  output cla_pkg::group_gp_t     group_gp,
  output logic                   carry_into_msb,
  output logic                   nonzero
);

  logic [BLOCK_WIDTH-1:0] gen;
  logic [BLOCK_WIDTH-1:0] prop;
  logic [BLOCK_WIDTH-1:0] carry;
  logic                   block_generate;
  logic                   block_propagate;

  // bitwise generate and propagate
  // propagate is the OR form, which still gives a correct carry
  assign gen  = operand_a & operand_b;
  assign prop = operand_a | operand_b;

  // every carry straight from the block carry-in
  // carry[0] comes out as carry_in itself
  for (genvar i = 0; i < BLOCK_WIDTH; i++) begin : g_carry
    assign carry[i] = cla_pkg::lookahead_carry(cla_pkg::word_t'(gen),
                                               cla_pkg::word_t'(prop),
                                               carry_in,
                                               i);
  end

  assign sum = operand_a ^ operand_b ^ carry;

  // group terms, carry-in excluded
  assign block_generate  = cla_pkg::lookahead_carry(cla_pkg::word_t'(gen),
                                                    cla_pkg::word_t'(prop),
                                                    1'b0,
                                                    BLOCK_WIDTH);
  assign block_propagate = &prop;

  assign group_gp = '{
    group_generate:  block_generate,
    group_propagate: block_propagate
  };

  // the top block's value feeds the overflow flag
  assign carry_into_msb = carry[BLOCK_WIDTH-1];

  // per-slice zero check, combined upstream
  assign nonzero = |sum;

endmodule

//--- design/carry_lookahead_unit.sv
`timescale 1ns/1ps

module carry_lookahead_unit #(
  parameter int NUM_BLOCKS = cla_pkg::WORD_WIDTH / cla_pkg::BLOCK_WIDTH
) (
  input  cla_pkg::group_gp_t [NUM_BLOCKS-1:0] group_gp,
  input  logic                                carry_in,
  output logic [NUM_BLOCKS-1:0]               block_carry,
  output logic                                carry_out
);

  logic [NUM_BLOCKS-1:0] group_generate;
  logic [NUM_BLOCKS-1:0] group_propagate;

  // split the structs into plain vectors
  for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_split
    assign group_generate[b]  = group_gp[b].group_generate;
    assign group_propagate[b] = group_gp[b].group_propagate;
  end

  // second level, same form as the bit level but over whole groups
  // block_carry[0] is carry_in unchanged
  for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_block_carry
    assign block_carry[b] = cla_pkg::lookahead_carry(
      cla_pkg::word_t'(group_generate),
      cla_pkg::word_t'(group_propagate),
      carry_in,
      b
    );
  end

  // carry out of the top group
  assign carry_out = cla_pkg::lookahead_carry(
    cla_pkg::word_t'(group_generate),
    cla_pkg::word_t'(group_propagate),
    carry_in,
    NUM_BLOCKS
  );

endmodule

//--- design/flag_unit.sv
`timescale 1ns/1ps

module flag_unit #(
  parameter int NUM_BLOCKS = cla_pkg::WORD_WIDTH / cla_pkg::BLOCK_WIDTH
) (
  input  logic                  sum_sign,
  input  logic                  operand_a_sign,
  input  logic                  carry_out,
  input  logic                  carry_into_msb,
  input  logic [NUM_BLOCKS-1:0] block_nonzero,
  output logic                  overflow,
  output logic                  not_equal,
  output logic                  less_than
);

  logic sum_negative_nonzero;

  // signed overflow from the top two carries
  assign overflow = carry_out ^ carry_into_msb;

  // in subtract mode a nonzero difference means a != b
  assign not_equal = |block_nonzero;

  assign sum_negative_nonzero = sum_sign & not_equal;

  // on overflow the sum sign is wrong, so a's sign decides
  assign less_than = overflow ? operand_a_sign : sum_negative_nonzero;

endmodule

//--- design/cla_adder.sv
`timescale 1ns/1ps

module cla_adder #(
  parameter int WORD_WIDTH  = cla_pkg::WORD_WIDTH,
  parameter int BLOCK_WIDTH = cla_pkg::BLOCK_WIDTH
) (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   in_valid,
  input  alu_status_pkg::operand_t operands,
  output logic                   out_valid,
  output alu_status_pkg::result_t  result
);

  localparam int NUM_BLOCKS = WORD_WIDTH / BLOCK_WIDTH;

  alu_status_pkg::operand_t operand_q;
  logic                     operand_valid;

  logic [WORD_WIDTH-1:0]                   sum_d;
  cla_pkg::group_gp_t [NUM_BLOCKS-1:0]     group_gp;
  logic [NUM_BLOCKS-1:0]                   block_carry;
  logic [NUM_BLOCKS-1:0]                   block_msb_carry;
  logic [NUM_BLOCKS-1:0]                   block_nonzero;
  logic                                    carry_out;
  logic                                    overflow;
  logic                                    not_equal;
  logic                                    less_than;
  alu_status_pkg::result_t                 result_d;

  // valid bits, one per register stage
  always_ff @(posedge clock) begin
    if (rst) begin
      operand_valid <= 1'b0;
      out_valid     <= 1'b0;
    end else begin
      operand_valid <= in_valid;
      out_valid     <= operand_valid;
    end
  end

  // data registers, loaded only for strobed items
  always_ff @(posedge clock) begin
    if (in_valid) begin
      operand_q <= operands;
    end
    if (operand_valid) begin
      result <= result_d;
    end
  end

  for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_block
    cla_block #(
      .BLOCK_WIDTH(BLOCK_WIDTH)
    ) i_block (
      .operand_a     (operand_q.operand_a[b*BLOCK_WIDTH +: BLOCK_WIDTH]),
      .operand_b     (operand_q.operand_b[b*BLOCK_WIDTH +: BLOCK_WIDTH]),
      .carry_in      (block_carry[b]),
      .sum           (sum_d[b*BLOCK_WIDTH +: BLOCK_WIDTH]),
      .group_gp      (group_gp[b]),
      .carry_into_msb(block_msb_carry[b]),
      .nonzero       (block_nonzero[b])
    );
  end

  carry_lookahead_unit #(
    .NUM_BLOCKS(NUM_BLOCKS)
  ) i_lookahead (
    .group_gp   (group_gp),
    .carry_in   (operand_q.carry_in),
    .block_carry(block_carry),
    .carry_out  (carry_out)
  );

  // only the top block's msb carry matters for overflow
  flag_unit #(
    .NUM_BLOCKS(NUM_BLOCKS)
  ) i_flags (
    .sum_sign      (sum_d[WORD_WIDTH-1]),
    .operand_a_sign(operand_q.operand_a[WORD_WIDTH-1]),
    .carry_out     (carry_out),
    .carry_into_msb(block_msb_carry[NUM_BLOCKS-1]),
    .block_nonzero (block_nonzero),
    .overflow      (overflow),
    .not_equal     (not_equal),
    .less_than     (less_than)
  );

  assign result_d = '{
    sum:       sum_d,
    overflow:  overflow,
    not_equal: not_equal,
    less_than: less_than
  };

endmodule

//--- bench/cla_scoreboard.sv
`timescale 1ns/1ps

module cla_scoreboard (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    exp_valid,
  input  alu_status_pkg::result_t exp_result,
  input  logic                    out_valid,
  input  alu_status_pkg::result_t result,
  output int                      error_count,
  output int                      pending
);

  alu_status_pkg::result_t expected_q[$];
  alu_status_pkg::result_t captured;
  logic                    captured_valid = 1'b0;
  logic                    flush = 1'b0;
  int                      errors = 0;
  int                      depth = 0;

  assign error_count = errors;
  assign pending     = depth;

  // take the expected value at the same edge the DUT takes the operands
  always @(posedge clock) begin
    flush          <= rst;
    captured_valid <= exp_valid & ~rst;
    captured       <= exp_result;
  end

  task automatic check_field(input string field,
                             input cla_pkg::word_t got,
                             input cla_pkg::word_t want);
    if (got !== want) begin
      $display("ERR %0t: %s got %h expected %h", $time, field, got, want);
      errors++;
    end
  endtask

  // queue upkeep first, then the DUT output of this cycle
  always @(negedge clock) begin
    alu_status_pkg::result_t expected;
    if (flush) begin
      expected_q.delete();
    end else if (captured_valid) begin
      expected_q.push_back(captured);
    end
    if (out_valid) begin
      if (expected_q.size() == 0) begin
        $display("out_valid at %0t with no expected result outstanding", $time);
        errors++;
      end else begin
        expected = expected_q.pop_front();
        check_field("sum", result.sum, expected.sum);
        check_field("overflow", cla_pkg::word_t'(result.overflow),
                    cla_pkg::word_t'(expected.overflow));
        check_field("not_equal", cla_pkg::word_t'(result.not_equal),
                    cla_pkg::word_t'(expected.not_equal));
        check_field("less_than", cla_pkg::word_t'(result.less_than),
                    cla_pkg::word_t'(expected.less_than));
      end
    end
    depth = expected_q.size();
  end

endmodule

//--- bench/cla_adder_chk.sv
`timescale 1ns/1ps

module cla_adder_chk (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    in_valid,
  input  logic                    out_valid,
  input  alu_status_pkg::result_t result
);

  localparam int MSB = cla_pkg::WORD_WIDTH - 1;

  // saturating count of edges since the last reset edge
  logic [1:0] edges_since_reset = '0;

  int assertion_failures = 0;

  always @(posedge clock) begin
    if (rst) begin
      edges_since_reset <= '0;
    end else if (edges_since_reset != 2'd3) begin
      edges_since_reset <= edges_since_reset + 2'd1;
    end
  end

  quiet_after_reset: assert property (@(posedge clock) $past(rst) |-> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      assertion_failures++;
    end

  // strobe at edge N shows up as out_valid sampled at edge N+2
  fixed_latency: assert property (@(posedge clock) disable iff (rst)
    edges_since_reset >= 2'd2 |-> out_valid == $past(in_valid, 2))
    else begin
      $error("out_valid does not follow in_valid two edges earlier");
      assertion_failures++;
    end

  not_equal_rule: assert property (@(posedge clock) disable iff (rst)
    out_valid |-> result.not_equal == (result.sum != '0))
    else begin
      $error("not_equal disagrees with the sum");
      assertion_failures++;
    end

  // on overflow a's sign is the inverse of the sum sign
  less_than_rule: assert property (@(posedge clock) disable iff (rst)
    out_valid |-> result.less_than == (result.overflow ? !result.sum[MSB]
                                                       : result.sum[MSB] & result.not_equal))
    else begin
      $error("less_than disagrees with overflow and sum sign");
      assertion_failures++;
    end

endmodule

bind cla_adder cla_adder_chk i_chk (
  .clock    (clock),
  .rst      (rst),
  .in_valid (in_valid),
  .out_valid(out_valid),
  .result   (result)
);

//--- bench/tb_cla_adder.sv
`timescale 1ns/1ps

module tb_cla_adder;

  localparam int CLOCK_PERIOD = 8;
  localparam int RESET_CYCLES = 4;
  localparam int TABLE_ROWS   = 20;
  localparam int RANDOM_ROWS  = 200;
  localparam int FLUSH_ROWS   = 6;
  localparam int DRAIN_LIMIT  = 8;
  localparam int WATCHDOG_NS  = (TABLE_ROWS + RANDOM_ROWS + RESET_CYCLES + 20) * CLOCK_PERIOD;
  localparam logic [31:0] SEED = 32'h55a97432;

  typedef struct packed {
    alu_status_pkg::operand_t operands;
    alu_status_pkg::result_t  expected;
  } vector_t;

  logic                     clock;
  logic                     rst;
  logic                     in_valid;
  alu_status_pkg::operand_t operands;
  logic                     out_valid;
  alu_status_pkg::result_t  result;
  logic                     exp_valid;
  alu_status_pkg::result_t  exp_result;
  int                       sb_errors;
  int                       pending;
  int                       tb_errors;
  vector_t                  vector_rows[$];

  cla_adder #(
    .WORD_WIDTH (cla_pkg::WORD_WIDTH),
    .BLOCK_WIDTH(cla_pkg::BLOCK_WIDTH)
  ) i_dut (
    .clock    (clock),
    .rst      (rst),
    .in_valid (in_valid),
    .operands (operands),
    .out_valid(out_valid),
    .result   (result)
  );

  cla_scoreboard i_scoreboard (
    .clock      (clock),
    .rst        (rst),
    .exp_valid  (exp_valid),
    .exp_result (exp_result),
    .out_valid  (out_valid),
    .result     (result),
    .error_count(sb_errors),
    .pending    (pending)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // expected result from two's complement rules on 32 bits
  function automatic alu_status_pkg::result_t expected_result(
    input alu_status_pkg::operand_t op
  );
    logic [32:0]             full_sum;
    logic [31:0]             low_sum;
    logic                    carry_into_top;
    alu_status_pkg::result_t res;
    full_sum       = {1'b0, op.operand_a} + {1'b0, op.operand_b} + 33'(op.carry_in);
    low_sum        = {1'b0, op.operand_a[30:0]} + {1'b0, op.operand_b[30:0]} + 32'(op.carry_in);
    carry_into_top = low_sum[31];
    res.sum        = full_sum[31:0];
    res.overflow   = full_sum[32] ^ carry_into_top;
    res.not_equal  = (res.sum != '0);
    res.less_than  = res.overflow ? op.operand_a[31] : (res.sum[31] & res.not_equal);
    return res;
  endfunction

  function automatic alu_status_pkg::operand_t random_operands(input int index);
    alu_status_pkg::operand_t op;
    op.operand_a = $urandom();
    op.operand_b = $urandom();
    op.carry_in  = 1'($urandom());
    // every eighth row compares a with itself
    if (index % 8 == 0) begin
      op.operand_b = ~op.operand_a;
      op.carry_in  = 1'b1;
    end
    return op;
  endfunction

  function automatic void add_row(input cla_pkg::word_t operand_a,
                                  input cla_pkg::word_t operand_b,
                                  input logic carry_in,
                                  input cla_pkg::word_t sum,
                                  input logic overflow,
                                  input logic not_equal,
                                  input logic less_than);
    vector_t row;
    row.operands.operand_a = operand_a;
    row.operands.operand_b = operand_b;
    row.operands.carry_in  = carry_in;
    row.expected.sum       = sum;
    row.expected.overflow  = overflow;
    row.expected.not_equal = not_equal;
    row.expected.less_than = less_than;
    vector_rows.push_back(row);
  endfunction

  task automatic build_vectors();
    // plain sums and wrap to zero
    add_row(32'h0000_0001, 32'h0000_0002, 1'b0, 32'h0000_0003, 1'b0, 1'b1, 1'b0);
    add_row(32'h0000_0001, 32'h0000_0002, 1'b1, 32'h0000_0004, 1'b0, 1'b1, 1'b0);
    add_row(32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    add_row(32'hffff_ffff, 32'h0000_0000, 1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    // long propagate chains over the block boundaries
    add_row(32'h0000_00ff, 32'h0000_0001, 1'b0, 32'h0000_0100, 1'b0, 1'b1, 1'b0);
    add_row(32'h0000_ffff, 32'h0000_0001, 1'b0, 32'h0001_0000, 1'b0, 1'b1, 1'b0);
    add_row(32'h00ff_ffff, 32'h0000_0001, 1'b0, 32'h0100_0000, 1'b0, 1'b1, 1'b0);
    add_row(32'h00ff_ffff, 32'h0000_0000, 1'b1, 32'h0100_0000, 1'b0, 1'b1, 1'b0);
    add_row(32'h1234_5678, 32'h0fed_cba9, 1'b0, 32'h2222_2221, 1'b0, 1'b1, 1'b0);
    add_row(32'h7fff_ff00, 32'h0000_00ff, 1'b1, 32'h8000_0000, 1'b1, 1'b1, 1'b0);
    // signed overflow both ways
    add_row(32'h7fff_ffff, 32'h0000_0001, 1'b0, 32'h8000_0000, 1'b1, 1'b1, 1'b0);
    add_row(32'h8000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000, 1'b1, 1'b0, 1'b1);
    // compare mode, b inverted with carry_in high
    add_row(32'h0000_0005, 32'hffff_fffa, 1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_0003, 32'hffff_fff8, 1'b1, 32'hffff_fffc, 1'b0, 1'b1, 1'b1);
    add_row(32'h0000_0007, 32'hffff_fffc, 1'b1, 32'h0000_0004, 1'b0, 1'b1, 1'b0);
    add_row(32'hffff_ffff, 32'hffff_fffe, 1'b1, 32'hffff_fffe, 1'b0, 1'b1, 1'b1);
    add_row(32'h8000_0000, 32'hffff_fffe, 1'b1, 32'h7fff_ffff, 1'b1, 1'b1, 1'b1);
    add_row(32'h7fff_ffff, 32'h7fff_ffff, 1'b1, 32'hffff_ffff, 1'b1, 1'b1, 1'b0);
    add_row(32'hffff_fffe, 32'h0000_0001, 1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic drive_item(input alu_status_pkg::operand_t op,
                            input alu_status_pkg::result_t expected);
    @(negedge clock);
    in_valid   = 1'b1;
    operands   = op;
    exp_valid  = 1'b1;
    exp_result = expected;
  endtask

  task automatic drive_idle();
    @(negedge clock);
    in_valid  = 1'b0;
    exp_valid = 1'b0;
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
    end while (pending != 0 && cycles < DRAIN_LIMIT);
    if (pending != 0) begin
      $display("%0d expected results never came out of the DUT", pending);
      tb_errors++;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: stimulus did not complete within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    alu_status_pkg::operand_t op;
    int                       assert_errors;
    clock      = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    operands   = '0;
    exp_valid  = 1'b0;
    exp_result = '0;
    tb_errors  = 0;
    void'($urandom(SEED));
    build_vectors();
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;

    foreach (vector_rows[i]) begin
      drive_item(vector_rows[i].operands, vector_rows[i].expected);
    end
    // random rows back to back after the table
    for (int i = 0; i < RANDOM_ROWS - FLUSH_ROWS; i++) begin
      op = random_operands(i);
      drive_item(op, expected_result(op));
    end
    drive_idle();
    wait_for_drain();

    // reset with items still in both registers
    for (int i = RANDOM_ROWS - FLUSH_ROWS; i < RANDOM_ROWS; i++) begin
      op = random_operands(i);
      drive_item(op, expected_result(op));
    end
    @(negedge clock);
    in_valid  = 1'b0;
    exp_valid = 1'b0;
    rst       = 1'b1;
    repeat (2) @(negedge clock);
    rst = 1'b0;
    // any stale out_valid here hits an empty queue
    repeat (4) @(posedge clock);

    assert_errors = i_dut.i_chk.assertion_failures;
    $display("errors: %0d from scoreboard, %0d from testbench, %0d from assertions",
             sb_errors, tb_errors, assert_errors);
    if (sb_errors + tb_errors + assert_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
design/cla_pkg.sv
design/alu_status_pkg.sv
design/cla_block.sv
design/carry_lookahead_unit.sv
design/flag_unit.sv
design/cla_adder.sv
bench/cla_scoreboard.sv
bench/cla_adder_chk.sv
bench/tb_cla_adder.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the cla_adder testbench with Verilator
# result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_cla_adder \
  -f files.f \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_cla_adder > sim.log 2>&1
cat sim.log

grep -qx "TEST PASSED" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation did not pass, see sim.log"; exit 1; }
